/* all.f */
design/sb_pkg.sv
design/sb_ram_if.sv
design/sb_ram_sp.sv
design/sb_conflict_resolve.sv
design/sb_top.sv
verif/sb_checker.sv
verif/sb_tb.sv

/* design/sb_conflict_resolve.sv */
/*
 * Conflict resolver
 * Read-modify-write of one record per object ID: counts hits with
 * saturation, flags already registered IDs, keeps the higher score and
 * box. Also serves record queries and the zero sweep run after reset
 * and on a clear command
 */
`timescale 1ns/100ps

module sb_conflict_resolve import sb_pkg::*; #(
  parameter int ID_WIDTH = ID_WIDTH_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  // Detection request
  input  logic                det_valid,
  input  logic [ID_WIDTH-1:0] det_id,
  input  score_t              det_score,
  input  bbox_t               det_bbox,
  // Query request
  input  logic                q_valid,
  input  logic [ID_WIDTH-1:0] q_id,
  // Sweep request
  input  logic                clear,
  // Status and results
  output logic                busy,
  output logic                det_done,
  output logic                det_conflict,
  output logic                det_replaced,
  output logic                q_done,
  output entry_t              q_entry,
  output logic                clear_done,
  // RAM side
  sb_ram_if.master            mem
);

  res_state_t          state;
  logic [ID_WIDTH-1:0] clr_addr;                        // Sweep pointer
  logic                clr_last;

  // Accepted request
  logic [ID_WIDTH-1:0] req_id;
  score_t              req_score;
  bbox_t               req_bbox;

  // Stored record fields
  entry_t              old_entry;
  logic                old_valid;
  hits_t               old_hits;
  score_t              old_score;

  // Updated record
  hits_t               new_hits;
  logic                take_new;
  entry_t              new_entry;

  assign busy     = (state != ST_IDLE);                 // Low only when idle
  assign clr_last = (clr_addr == {ID_WIDTH{1'b1}});

  // Unpack the word returned by the read
  assign old_entry = mem.rdata;
  assign old_valid = old_entry[VALID_BIT];
  assign old_hits  = old_entry[HITS_LSB +: HITS_WIDTH];
  assign old_score = old_entry[SCORE_LSB +: SCORE_WIDTH];

  // Update rule
  always_comb begin
    if (!old_valid) begin
      new_hits = hits_t'(1);                            // First sighting
    end else if (old_hits == HITS_MAX) begin
      new_hits = HITS_MAX;                              // Saturate
    end else begin
      new_hits = old_hits + hits_t'(1);
    end

    take_new = !old_valid || (req_score > old_score);   // Ties keep old data

    new_entry                             = old_entry;
    new_entry[VALID_BIT]                  = 1'b1;
    new_entry[HITS_LSB +: HITS_WIDTH]     = new_hits;
    if (take_new) begin
      new_entry[SCORE_LSB +: SCORE_WIDTH] = req_score;
      new_entry[BBOX_LSB +: BBOX_WIDTH]   = req_bbox;
    end
  end

  // RAM strobes follow the state
  always_comb begin
    mem.address = req_id;
    mem.wdata   = new_entry;
    mem.cs      = 1'b0;
    mem.we      = 1'b0;
    mem.oe      = 1'b0;
    case (state)
      ST_CLEAR: begin
        mem.address = clr_addr;
        mem.wdata   = '0;                               // Empty record
        mem.cs      = 1'b1;
        mem.we      = 1'b1;
      end
      ST_RD, ST_QRD: begin
        mem.cs = 1'b1;
        mem.oe = 1'b1;                                  // Data next cycle
      end
      ST_WB: begin
        mem.cs = 1'b1;
        mem.we = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // FSM and done pulses
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= ST_CLEAR;                         // Sweep out of reset
      clr_addr     <= '0;
      det_done     <= 1'b0;
      det_conflict <= 1'b0;
      det_replaced <= 1'b0;
      q_done       <= 1'b0;
      clear_done   <= 1'b0;
    end else begin
      det_done   <= 1'b0;                               // Single cycle pulses
      q_done     <= 1'b0;
      clear_done <= 1'b0;
      case (state)
        ST_CLEAR: begin
          clr_addr <= clr_addr + 1'b1;                  // Wraps to zero at end
          if (clr_last) begin
            clear_done <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (clear) begin                              // Highest priority
            clr_addr <= '0;
            state    <= ST_CLEAR;
          end else if (det_valid) begin
            state <= ST_RD;
          end else if (q_valid) begin
            state <= ST_QRD;
          end
        end
        ST_RD: begin
          state <= ST_WB;
        end
        ST_WB: begin
          det_done     <= 1'b1;
          det_conflict <= old_valid;                    // Slot already taken
          det_replaced <= take_new;
          state        <= ST_IDLE;
        end
        ST_QRD: begin
          state <= ST_QOUT;
        end
        ST_QOUT: begin
          q_done <= 1'b1;
          state  <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Request and query payload
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      if (det_valid) begin
        req_id    <= det_id;
        req_score <= det_score;
        req_bbox  <= det_bbox;
      end else if (q_valid) begin
        req_id <= q_id;
      end
    end
    if (state == ST_QOUT) begin
      q_entry <= mem.rdata;                             // Read result
    end
  end

endmodule

/* design/sb_pkg.sv */
/*
 * Scoreboard package
 * Field types, stored record layout, resolver state encoding and
 * default sizes shared by the registration scoreboard
 */
package sb_pkg;

  localparam int ID_WIDTH_DEF = 8;                      // 256 object slots

  // Record field widths
  localparam int SCORE_WIDTH  = 10;
  localparam int BBOX_WIDTH   = 32;                     // Four 8-bit coordinates
  localparam int HITS_WIDTH   = 4;
  localparam int ENTRY_WIDTH  = 1 + HITS_WIDTH + SCORE_WIDTH + BBOX_WIDTH;

  // Field positions inside the record, bbox at the bottom
  localparam int BBOX_LSB     = 0;
  localparam int SCORE_LSB    = BBOX_LSB + BBOX_WIDTH;
  localparam int HITS_LSB     = SCORE_LSB + SCORE_WIDTH;
  localparam int VALID_BIT    = HITS_LSB + HITS_WIDTH;  // Top bit

  typedef logic [SCORE_WIDTH-1:0] score_t;              // Confidence score
  typedef logic [BBOX_WIDTH-1:0]  bbox_t;               // Opaque to the design
  typedef logic [HITS_WIDTH-1:0]  hits_t;               // Saturating hit count
  typedef logic [ENTRY_WIDTH-1:0] entry_t;              // valid | hits | score | bbox

  localparam hits_t HITS_MAX = '1;                      // Saturation point

  // Resolver FSM
  typedef enum logic [2:0] {
    ST_CLEAR,                                           // Zero sweep
    ST_IDLE,                                            // Accepting strobes
    ST_RD,                                              // Detection read
    ST_WB,                                              // Detection write back
    ST_QRD,                                             // Query read
    ST_QOUT                                             // Query capture
  } res_state_t;

endpackage

/* design/sb_ram_if.sv */
/*
 * Single-port RAM bus
 * Address, write data, read data and the cs/we/oe strobes between
 * the resolver (master) and the memory (ram)
 */
`timescale 1ns/100ps

interface sb_ram_if import sb_pkg::*; #(
  parameter int DATA_WIDTH = ENTRY_WIDTH,
  parameter int ADDR_WIDTH = ID_WIDTH_DEF
);

  logic [ADDR_WIDTH-1:0] address;                       // Word address
  logic [DATA_WIDTH-1:0] wdata;                         // Write data
  logic [DATA_WIDTH-1:0] rdata;                         // Registered read data
  logic                  cs;                            // Chip select
  logic                  we;                            // Write enable
  logic                  oe;                            // Read enable

  modport master (
    output address,
    output wdata,
    output cs,
    output we,
    output oe,
    input  rdata
  );

  modport ram (
    input  address,
    input  wdata,
    input  cs,
    input  we,
    input  oe,
    output rdata
  );

endinterface

/* design/sb_ram_sp.sv */
/*
 * Single-port synchronous RAM
 * 2^ADDR_WIDTH words, write on cs and we, registered read on cs and oe
 * with we low; read data holds between reads. No reset on the array
 */
`timescale 1ns/100ps

module sb_ram_sp import sb_pkg::*; #(
  parameter int DATA_WIDTH = ENTRY_WIDTH,
  parameter int ADDR_WIDTH = ID_WIDTH_DEF
) (
  input logic   clk,
  sb_ram_if.ram mem
);

  localparam int RAM_DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] storage [RAM_DEPTH];           // Word array
  logic [DATA_WIDTH-1:0] rd_q;                          // Output register

  // Write port, lands at the requesting edge
  always_ff @(posedge clk) begin
    if (mem.cs && mem.we) begin
      storage[mem.address] <= mem.wdata;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    if (mem.cs && mem.oe && !mem.we) begin
      rd_q <= storage[mem.address];                    // Held until next read
    end
  end

  assign mem.rdata = rd_q;

endmodule

/* design/sb_top.sv */
/*
 * Registration scoreboard top
 * Conflict resolver and single-port record RAM joined by the RAM bus,
 * one record per object ID
 */
`timescale 1ns/100ps

module sb_top import sb_pkg::*; #(
  parameter int ID_WIDTH = ID_WIDTH_DEF
) (
  input  logic                clk,
  input  logic                arst_n,
  // Detection
  input  logic                det_valid,
  input  logic [ID_WIDTH-1:0] det_id,
  input  score_t              det_score,
  input  bbox_t               det_bbox,
  // Query
  input  logic                q_valid,
  input  logic [ID_WIDTH-1:0] q_id,
  // Clear
  input  logic                clear,
  // Status and results
  output logic                busy,
  output logic                det_done,
  output logic                det_conflict,
  output logic                det_replaced,
  output logic                q_done,
  output entry_t              q_entry,
  output logic                clear_done
);

  // Record bus, ID is the address
  sb_ram_if #(
    .DATA_WIDTH (ENTRY_WIDTH),
    .ADDR_WIDTH (ID_WIDTH)
  ) ram_bus ();

  sb_conflict_resolve #(
    .ID_WIDTH (ID_WIDTH)
  ) resolve_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .det_valid    (det_valid),
    .det_id       (det_id),
    .det_score    (det_score),
    .det_bbox     (det_bbox),
    .q_valid      (q_valid),
    .q_id         (q_id),
    .clear        (clear),
    .busy         (busy),
    .det_done     (det_done),
    .det_conflict (det_conflict),
    .det_replaced (det_replaced),
    .q_done       (q_done),
    .q_entry      (q_entry),
    .clear_done   (clear_done),
    .mem          (ram_bus.master)
  );

  sb_ram_sp #(
    .DATA_WIDTH (ENTRY_WIDTH),
    .ADDR_WIDTH (ID_WIDTH)
  ) ram_i (
    .clk (clk),
    .mem (ram_bus.ram)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the scoreboard testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
OBJ_DIR=obj_dir

rm -rf "$OBJ_DIR"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module sb_tb \
  -Mdir "$OBJ_DIR" \
  -o sb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status, see $BUILD_LOG"
  exit 1
fi

"./$OBJ_DIR/sb_sim" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* verif/sb_checker.sv */
/*
 * Resolver protocol checker
 * Done pulses exclusive, no read and write in one RAM access, busy
 * drops only with a done pulse
 */
`timescale 1ns/100ps

module sb_checker (
  input logic   clk,
  input logic   arst_n,
  input logic   busy,
  input logic   det_done,
  input logic   q_done,
  input logic   clear_done,
  input logic   cs,                                      // RAM strobes
  input logic   we,
  input logic   oe
);

  // One completion per cycle at most
  done_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({det_done, q_done, clear_done})
  ) else $error("more than one done pulse in a cycle");

  // Single port, never both directions
  ram_dir_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(cs && we && oe)
  ) else $error("RAM access with we and oe both high");

  // Back to idle only when an operation completes
  busy_fall_done: assert property (
    @(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> (det_done || q_done || clear_done)
  ) else $error("busy fell without a done pulse");

endmodule

/* verif/sb_tb.sv */
/*
 * Scoreboard testbench
 * LCG driven detections, queries and clears against a record model,
 * flags and query results compared at every done pulse
 */
`timescale 1ns/100ps

module sb_tb import sb_pkg::*;;

  localparam int ID_W      = 8;
  localparam int N_SLOTS   = 1 << ID_W;
  localparam int N_Q_RST   = 8;                          // Queries after reset sweep
  localparam int N_TRACK   = 4;                          // Tracked IDs
  localparam int N_REPEAT  = 10;                         // Detections per tracked ID
  localparam int N_SAT     = 20;                         // Past the hit limit
  localparam int N_Q_CLR   = 16;
  localparam int N_MIX     = 2000;
  localparam int N_OPS     = N_Q_RST + 2 + 2 * N_TRACK * N_REPEAT + 2 + N_SAT + 1
                             + N_TRACK + 1 + N_Q_CLR + 1 + N_MIX;
  localparam int SWEEP_CYC = N_SLOTS + 2;
  localparam int TIMEOUT   = 2 * (2 * SWEEP_CYC + 4 * N_OPS) + 4;

  logic          clk;
  logic          arst_n;
  logic          det_valid;
  logic [ID_W-1:0] det_id;
  score_t        det_score;
  bbox_t         det_bbox;
  logic          q_valid;
  logic [ID_W-1:0] q_id;
  logic          clear;
  logic          busy;
  logic          det_done;
  logic          det_conflict;
  logic          det_replaced;
  logic          q_done;
  entry_t        q_entry;
  logic          clear_done;

  entry_t        model [N_SLOTS];                        // Expected RAM contents
  logic [31:0]   rng_state = 32'hb010;
  int unsigned   cycle_cnt = 0;

  sb_top #(.ID_WIDTH(ID_W)) dut_i (.*);

  bind sb_conflict_resolve sb_checker chk_i (
    .clk(clk), .arst_n(arst_n), .busy(busy), .det_done(det_done), .q_done(q_done),
    .clear_done(clear_done), .cs(mem.cs), .we(mem.we), .oe(mem.oe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                               // 4 ns period
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the DUT never finished an operation", cycle_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "hang");
    end
  end

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function logic [ID_W-1:0] rand_id();
    logic [31:0] r;
    r = next_rand();
    return r[23:16];                                     // Upper bits mix better
  endfunction

  function score_t rand_score();
    logic [31:0] r;
    r = next_rand();
    return r[31:22];
  endfunction

  // Reference update of one record for a detection
  function automatic entry_t apply_detection(input entry_t cur, input score_t s,
                                             input bbox_t b, output logic conflict,
                                             output logic replaced);
    logic   vld;
    hits_t  h;
    score_t sc;
    bbox_t  bb;
    {vld, h, sc, bb} = cur;
    conflict = vld;
    replaced = !vld || (s > sc);                         // Strictly higher only
    if (!vld) h = 4'd1;
    else if (h != 4'd15) h = h + 4'd1;                   // Stick at 15
    if (replaced) begin
      sc = s;
      bb = b;
    end
    return {1'b1, h, sc, bb};
  endfunction

  task automatic check_entry(input string name, input entry_t exp, input entry_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "record mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic wait_idle();
    while (busy) @(negedge clk);
  endtask

  task automatic send_detection(input logic [ID_W-1:0] id, input score_t s, input bbox_t b);
    logic exp_conf;
    logic exp_repl;
    wait_idle();
    det_valid = 1'b1;
    det_id    = id;
    det_score = s;
    det_bbox  = b;
    @(negedge clk);
    det_valid = 1'b0;
    while (!det_done) @(negedge clk);
    model[id] = apply_detection(model[id], s, b, exp_conf, exp_repl);
    check_flag("det_conflict", exp_conf, det_conflict);
    check_flag("det_replaced", exp_repl, det_replaced);
  endtask

  task automatic issue_query(input logic [ID_W-1:0] id);
    wait_idle();
    q_valid = 1'b1;
    q_id    = id;
    @(negedge clk);
    q_valid = 1'b0;
    while (!q_done) @(negedge clk);
    check_entry("q_entry", model[id], q_entry);
  endtask

  task automatic sweep_clear();
    wait_idle();
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    while (!clear_done) @(negedge clk);
    foreach (model[i]) model[i] = '0;
  endtask

  initial begin
    logic [ID_W-1:0] track_ids [N_TRACK];
    logic [ID_W-1:0] id;
    logic [31:0]     r;
    arst_n    = 1'b0;
    det_valid = 1'b0;
    det_id    = '0;
    det_score = '0;
    det_bbox  = '0;
    q_valid   = 1'b0;
    q_id      = '0;
    clear     = 1'b0;
    foreach (model[i]) model[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Post-reset sweep, then empty slots
    while (!clear_done) @(negedge clk);
    check_flag("busy", 1'b0, busy);
    repeat (N_Q_RST) issue_query(rand_id());

    // First sighting of an ID
    id = rand_id();
    send_detection(id, rand_score(), next_rand());
    issue_query(id);

    // Repeats with small scores so ties show up
    foreach (track_ids[i]) track_ids[i] = rand_id();
    for (int k = 0; k < N_REPEAT; k++) begin
      foreach (track_ids[i]) begin
        r = next_rand();
        send_detection(track_ids[i], score_t'(r[27:24]), next_rand());
        issue_query(track_ids[i]);
      end
    end
    send_detection(track_ids[0], model[track_ids[0]][SCORE_LSB +: SCORE_WIDTH], next_rand());
    issue_query(track_ids[0]);                           // Equal score kept old box

    // Hit counter saturation
    id = rand_id();
    repeat (N_SAT) send_detection(id, rand_score(), next_rand());
    issue_query(id);

    // Mid-run clear, written slots revisited first
    sweep_clear();
    foreach (track_ids[i]) issue_query(track_ids[i]);
    issue_query(id);
    repeat (N_Q_CLR) issue_query(rand_id());
    send_detection(id, rand_score(), next_rand());       // Saturated slot now empty

    // Random mix over all IDs
    for (int k = 0; k < N_MIX; k++) begin
      r = next_rand();
      if (r[28]) send_detection(rand_id(), rand_score(), next_rand());
      else issue_query(rand_id());
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
